//--- filelist.f
verilog/hist_cfg_pkg.sv
verilog/hist_stream_pkg.sv
verilog/hist_event_sequencer.sv
verilog/hist_bin_mapper.sv
verilog/hist_bin_memory.sv
verilog/hist_peak_tracker.sv
verilog/hist_top.sv
verification/hist_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f filelist.f --top-module hist_tb -o hist_sim

./obj_dir/hist_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished cleanly"

//--- verification/hist_tb.sv
`timescale 1ns/100ps
`default_nettype none

module hist_tb
    import hist_cfg_pkg::*;
    import hist_stream_pkg::*;
();

    // events per phase of one frame
    localparam int FRAME   = PIXELS * EVENTS_PER_PIXEL * ACQS;
    localparam int CNT_MAX = (1 << COUNT_W) - 1;
    localparam int NTESTS  = 7;

    // one table row with per pixel fields packed low pixel first
    typedef struct packed {
        logic [PIXELS-1:0][BIN_W-1:0] coarse;
        logic [PIXELS-1:0][BIN_W-1:0] fine;
        // clustered events out of each group of EVENTS_PER_PIXEL
        logic [PIXELS-1:0][3:0]       frac;
        // 0 none, 1 anywhere, 2 other coarse bins, 3 neighbour fine bin
        logic [PIXELS-1:0][1:0]       noise;
        logic [7:0]                   gap;
        // next frame follows without waiting for reports
        logic                         chain;
        // reset in the middle of a first attempt
        logic                         abort;
    } row_t;

    logic         clk;
    logic         combin_res;
    logic         ts_valid;
    ts_event_t    ts_in;
    logic         report_valid;
    peak_report_t report;

    row_t               tests [NTESTS];
    string              names [NTESTS];
    logic [TS_W-1:0]    ev_ts [2*FRAME];
    logic [31:0]        lcg_state = 32'h716d_8011;
    peak_report_t       exp_q [$];
    int                 id_q [$];
    peak_report_t       mon_want;
    int                 mon_id;
    int                 test_errs  = 0;
    int                 tests_run  = 0;
    int                 tests_ok   = 0;
    int                 mismatches = 0;
    int                 timeouts   = 0;
    int                 t;

    hist_top #(
        .TS_W(TS_W), .BIN_W(BIN_W), .COUNT_W(COUNT_W), .PIXELS(PIXELS),
        .EVENTS_PER_PIXEL(EVENTS_PER_PIXEL), .ACQS(ACQS)
    ) u_dut (
        .clk(clk), .combin_res(combin_res), .ts_valid(ts_valid), .ts_in(ts_in),
        .report_valid(report_valid), .report(report)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // both phases of one frame with coarse events first
    task automatic gen_frame(input row_t r);
        int idx;
        int p;
        int e;
        logic [BIN_W-1:0] c;
        logic [BIN_W-1:0] f;
        logic [BIN_W-1:0] hi;
        logic [7:0] rnd;
        for (idx = 0; idx < 2 * FRAME; idx++) begin
            p = (idx / EVENTS_PER_PIXEL) % PIXELS;
            e = idx % EVENTS_PER_PIXEL;
            c = r.coarse[p];
            f = r.fine[p];
            lcg_state = lcg_next(lcg_state);
            rnd = lcg_state[23:16];
            if (e < int'(r.frac[p]) || r.noise[p] == 2'd0) begin
                ev_ts[idx] = {c, f};
            end else if (r.noise[p] == 2'd1) begin
                ev_ts[idx] = rnd;
            end else if (r.noise[p] == 2'd2) begin
                // offset 1..15 never lands on the target coarse bin
                hi = c + 4'd1 + (rnd[3:0] % 4'd15);
                // same fine bits as the target so only the coarse filter drops it
                ev_ts[idx] = {hi, f};
            end else begin
                ev_ts[idx] = {c, f ^ BIN_W'(1)};
            end
        end
    endtask

    // reference histograms with saturation and strictly greater peaks
    task automatic build_expected(input int test_id);
        int cnt [PIXELS][2**BIN_W];
        int mx [PIXELS];
        logic [BIN_W-1:0] arg [PIXELS];
        logic [BIN_W-1:0] cpk [PIXELS];
        logic [BIN_W-1:0] hi;
        logic [BIN_W-1:0] bin;
        peak_report_t want;
        int ph;
        int i;
        int p;
        int b;
        for (ph = 0; ph < 2; ph++) begin
            for (p = 0; p < PIXELS; p++) begin
                mx[p] = 0;
                arg[p] = '0;
                for (b = 0; b < 2**BIN_W; b++) begin
                    cnt[p][b] = 0;
                end
            end
            for (i = 0; i < FRAME; i++) begin
                p = (i / EVENTS_PER_PIXEL) % PIXELS;
                hi = ev_ts[ph*FRAME + i][TS_W-1 -: BIN_W];
                bin = (ph == 0) ? hi : ev_ts[ph*FRAME + i][BIN_W-1:0];
                // fine pass ignores hits outside the coarse peak
                if (ph == 0 || hi == cpk[p]) begin
                    if (cnt[p][bin] < CNT_MAX) begin
                        cnt[p][bin] = cnt[p][bin] + 1;
                    end
                    if (cnt[p][bin] > mx[p]) begin
                        mx[p] = cnt[p][bin];
                        arg[p] = bin;
                    end
                end
            end
            if (ph == 0) begin
                cpk = arg;
            end
        end
        for (p = 0; p < PIXELS; p++) begin
            want.pix = PIX_W'(p);
            want.coarse_bin = cpk[p];
            want.fine_bin = arg[p];
            want.count = COUNT_W'(mx[p]);
            exp_q.push_back(want);
            id_q.push_back(test_id);
        end
    endtask

    // one strobe per falling edge with gap idle cycles in between
    task automatic drive_events(input int first, input int n, input int gap);
        int i;
        int g;
        for (i = first; i < first + n; i++) begin
            @(negedge clk);
            ts_valid = 1'b1;
            ts_in.ts = ev_ts[i];
            for (g = 0; g < gap; g++) begin
                @(negedge clk);
                ts_valid = 1'b0;
            end
        end
    endtask

    task automatic wait_reports();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout at %0t: %0d reports never arrived", $time, exp_q.size());
            timeouts++;
        end
    endtask

    // compare reports in arrival order
    always @(negedge clk) begin
        if (report_valid) begin
            if (exp_q.size() == 0) begin
                $display("report for pixel %0d arrived at %0t with none expected",
                         report.pix, $time);
                mismatches++;
            end else begin
                mon_want = exp_q.pop_front();
                mon_id = id_q.pop_front();
                if (report !== mon_want) begin
                    $display("Fail %0t: test %0d pix %0d got c%0d f%0d n%0d want c%0d f%0d n%0d",
                             $time, mon_id, report.pix, report.coarse_bin, report.fine_bin,
                             report.count, mon_want.coarse_bin, mon_want.fine_bin, mon_want.count);
                    mismatches++;
                    test_errs++;
                end
                // last pixel closes the test
                if (int'(mon_want.pix) == PIXELS - 1) begin
                    $display("test %0d %s: %s", mon_id, names[mon_id],
                             (test_errs == 0) ? "ok" : "mismatch");
                    tests_run++;
                    if (test_errs == 0) begin
                        tests_ok++;
                    end
                    test_errs = 0;
                end
            end
        end
    end

    initial begin
        combin_res = 1'b0;
        ts_valid = 1'b0;
        ts_in = '0;
        names[0] = "dense cluster";
        tests[0] = '{16'h9c35, 16'h2e71, 16'h7777, 8'h55, 8'd0, 1'b0, 1'b0};
        names[1] = "out-of-bin noise";
        tests[1] = '{16'h1f60, 16'h48b3, 16'h4444, 8'haa, 8'd2, 1'b0, 1'b0};
        names[2] = "tie";
        tests[2] = '{16'h52d8, 16'h6c09, 16'h4444, 8'hff, 8'd1, 1'b0, 1'b0};
        names[3] = "saturation";
        tests[3] = '{16'ha3e7, 16'h1f5c, 16'h8888, 8'h00, 8'd0, 1'b0, 1'b0};
        names[4] = "frame a";
        tests[4] = '{16'h3333, 16'h5555, 16'h6666, 8'h55, 8'd0, 1'b1, 1'b0};
        // arrives while frame a still reports
        names[5] = "frame b";
        tests[5] = '{16'hcccc, 16'haaaa, 16'h6666, 8'h55, 8'd0, 1'b0, 1'b0};
        names[6] = "reset mid-frame";
        tests[6] = '{16'h7e27, 16'h3a94, 16'h5555, 8'h99, 8'd1, 1'b0, 1'b1};
        repeat (5) @(negedge clk);
        combin_res = 1'b1;

        for (t = 0; t < NTESTS && timeouts == 0; t++) begin
            gen_frame(tests[t]);
            if (tests[t].abort) begin
                // partial coarse pass that a reset drops
                drive_events(0, 60, int'(tests[t].gap));
                @(negedge clk);
                ts_valid = 1'b0;
                combin_res = 1'b0;
                repeat (3) @(negedge clk);
                combin_res = 1'b1;
                gen_frame(tests[t]);
            end
            build_expected(t);
            drive_events(0, 2 * FRAME, int'(tests[t].gap));
            if (!tests[t].chain) begin
                @(negedge clk);
                ts_valid = 1'b0;
                wait_reports();
            end
        end

        $display("%0d tests run, %0d ok, %0d mismatches, %0d timeouts",
                 tests_run, tests_ok, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0 && tests_run == NTESTS && tests_ok == tests_run) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/hist_top.sv
`timescale 1ns/100ps
`default_nettype none

module hist_top
    import hist_stream_pkg::*;
#(
    parameter int TS_W             = hist_cfg_pkg::TS_W,
    parameter int BIN_W            = hist_cfg_pkg::BIN_W,
    parameter int COUNT_W          = hist_cfg_pkg::COUNT_W,
    parameter int PIXELS           = hist_cfg_pkg::PIXELS,
    parameter int EVENTS_PER_PIXEL = hist_cfg_pkg::EVENTS_PER_PIXEL,
    parameter int ACQS             = hist_cfg_pkg::ACQS
) (
    input  logic         clk,
    input  logic         combin_res,
    input  logic         ts_valid,
    input  ts_event_t    ts_in,
    output logic         report_valid,
    output peak_report_t report
);

    logic                         tag_valid;
    tagged_event_t                tag;
    logic                         map_valid;
    bin_update_t                  map;
    logic                         upd_valid;
    bin_update_t                  upd;
    // fed back from the tracker for the fine pass filter
    logic [PIXELS-1:0][BIN_W-1:0] coarse_peaks;

    hist_event_sequencer #(
        .PIXELS(PIXELS), .EVENTS_PER_PIXEL(EVENTS_PER_PIXEL), .ACQS(ACQS)
    ) u_seq (
        .clk(clk), .combin_res(combin_res), .ts_valid(ts_valid), .ts_in(ts_in),
        .tag_valid(tag_valid), .tag(tag)
    );

    hist_bin_mapper #(.PIXELS(PIXELS), .TS_W(TS_W), .BIN_W(BIN_W)) u_map (
        .clk(clk), .combin_res(combin_res), .tag_valid(tag_valid), .tag(tag),
        .coarse_peaks(coarse_peaks), .map_valid(map_valid), .map(map)
    );

    hist_bin_memory #(.PIXELS(PIXELS), .BIN_W(BIN_W), .COUNT_W(COUNT_W)) u_mem (
        .clk(clk), .combin_res(combin_res), .map_valid(map_valid), .map(map),
        .upd_valid(upd_valid), .upd(upd)
    );

    hist_peak_tracker #(.PIXELS(PIXELS), .BIN_W(BIN_W), .COUNT_W(COUNT_W)) u_peak (
        .clk(clk), .combin_res(combin_res), .upd_valid(upd_valid), .upd(upd),
        .coarse_peaks(coarse_peaks), .report_valid(report_valid), .report(report)
    );

endmodule

`default_nettype wire

//--- verilog/hist_peak_tracker.sv
`timescale 1ns/100ps
`default_nettype none

module hist_peak_tracker
    import hist_cfg_pkg::*;
    import hist_stream_pkg::*;
#(
    parameter int PIXELS  = hist_cfg_pkg::PIXELS,
    parameter int BIN_W   = hist_cfg_pkg::BIN_W,
    parameter int COUNT_W = hist_cfg_pkg::COUNT_W
) (
    input  logic                         clk,
    input  logic                         combin_res,
    input  logic                         upd_valid,
    input  bin_update_t                  upd,
    output logic [PIXELS-1:0][BIN_W-1:0] coarse_peaks,
    output logic                         report_valid,
    output peak_report_t                 report
);

    logic [PIXELS-1:0][COUNT_W-1:0] run_max;
    logic [PIXELS-1:0][COUNT_W-1:0] max_next;
    logic [PIXELS-1:0][BIN_W-1:0]   run_arg;
    logic [PIXELS-1:0][BIN_W-1:0]   arg_next;
    logic [PIXELS-1:0][BIN_W-1:0]   peak_q;
    logic [PIXELS-1:0][BIN_W-1:0]   snap_fine;
    logic [PIXELS-1:0][COUNT_W-1:0] snap_cnt;
    logic                           in_coarse;
    logic                           emit_busy;
    logic [PIX_W-1:0]               emit_idx;
    logic                           upd_last;
    logic                           fine_last;

    assign upd_last  = upd_valid && upd.last;
    assign fine_last = upd_last && (upd.phase == PHASE_FINE);

    // strictly greater only, so a tie stays with the earlier bin
    always_comb begin
        max_next = run_max;
        arg_next = run_arg;
        if (upd_valid && upd.keep && upd.count > run_max[upd.pix]) begin
            max_next[upd.pix] = upd.count;
            arg_next[upd.pix] = upd.bin;
        end
    end

    // while the coarse tail drains, early fine events already see
    // the settled argmax of the lower pixels
    assign coarse_peaks = in_coarse ? run_arg : peak_q;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            run_max      <= '0;
            run_arg      <= '0;
            peak_q       <= '0;
            in_coarse    <= 1'b1;
            emit_busy    <= 1'b0;
            emit_idx     <= '0;
            report_valid <= 1'b0;
        end else begin
            if (upd_last) begin
                run_max   <= '0;
                run_arg   <= '0;
                in_coarse <= (upd.phase == PHASE_FINE);
                if (upd.phase == PHASE_COARSE) begin
                    peak_q <= arg_next;
                end
            end else begin
                run_max <= max_next;
                run_arg <= arg_next;
            end
            // walk the snapshot one pixel per cycle
            if (fine_last) begin
                emit_busy <= 1'b1;
                emit_idx  <= '0;
            end else if (emit_busy) begin
                emit_idx <= emit_idx + 1'b1;
                if (emit_idx == PIX_W'(PIXELS - 1)) begin
                    emit_busy <= 1'b0;
                end
            end
            report_valid <= emit_busy;
        end
    end

    // snapshot frees the running state for the next frame
    always_ff @(posedge clk) begin
        if (fine_last) begin
            snap_fine <= arg_next;
            snap_cnt  <= max_next;
        end
        if (emit_busy) begin
            report.pix        <= emit_idx;
            report.coarse_bin <= peak_q[emit_idx];
            report.fine_bin   <= snap_fine[emit_idx];
            report.count      <= snap_cnt[emit_idx];
        end
    end

    // reports only start two cycles after a fine last update
    assert property (@(posedge clk) disable iff (!combin_res)
        $rose(report_valid) |-> $past(upd_valid && upd.last && upd.phase == PHASE_FINE, 2));

endmodule

`default_nettype wire

//--- verilog/hist_bin_memory.sv
`timescale 1ns/100ps
`default_nettype none

module hist_bin_memory
    import hist_cfg_pkg::*;
    import hist_stream_pkg::*;
#(
    parameter int PIXELS  = hist_cfg_pkg::PIXELS,
    parameter int BIN_W   = hist_cfg_pkg::BIN_W,
    parameter int COUNT_W = hist_cfg_pkg::COUNT_W
) (
    input  logic        clk,
    input  logic        combin_res,
    input  logic        map_valid,
    input  bin_update_t map,
    output logic        upd_valid,
    output bin_update_t upd
);

    localparam int DEPTH  = PIXELS * (2 ** BIN_W);
    localparam int ADDR_W = PIX_W + BIN_W;
    localparam logic [COUNT_W-1:0] CNT_MAX = '1;

    // one histogram per pixel with bins side by side
    logic [COUNT_W-1:0] cnt_mem [DEPTH];
    // bin holds a count of this phase
    logic [DEPTH-1:0]   bin_vld;
    logic [ADDR_W-1:0]  addr;
    logic [COUNT_W-1:0] cnt_cur;
    logic [COUNT_W-1:0] cnt_new;
    logic               wr_en;

    assign addr    = {map.pix, map.bin};
    assign wr_en   = map_valid && map.keep;
    assign cnt_cur = cnt_mem[addr];

    // stale bins read as empty and full bins stick at max
    always_comb begin
        if (!bin_vld[addr]) begin
            cnt_new = COUNT_W'(1);
        end else if (cnt_cur == CNT_MAX) begin
            cnt_new = CNT_MAX;
        end else begin
            cnt_new = cnt_cur + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            bin_vld   <= '0;
            upd_valid <= 1'b0;
        end else begin
            upd_valid <= map_valid;
            if (map_valid && map.last) begin
                // drop every flag so the next phase starts on empty bins
                bin_vld <= '0;
            end else if (wr_en) begin
                bin_vld[addr] <= 1'b1;
            end
        end
    end

    // read-modify-write in one cycle so back to back hits see the new value
    always_ff @(posedge clk) begin
        if (wr_en) begin
            cnt_mem[addr] <= cnt_new;
        end
        if (map_valid) begin
            upd.pix   <= map.pix;
            upd.bin   <= map.bin;
            upd.count <= wr_en ? cnt_new : '0;
            upd.phase <= map.phase;
            upd.keep  <= map.keep;
            upd.last  <= map.last;
        end
    end

    // a hit on a live bin never lowers its count so a full bin cannot wrap
    assert property (@(posedge clk) disable iff (!combin_res)
        wr_en && bin_vld[addr] |=> upd.count >= $past(cnt_cur));

endmodule

`default_nettype wire

//--- verilog/hist_bin_mapper.sv
`timescale 1ns/100ps
`default_nettype none

module hist_bin_mapper
    import hist_cfg_pkg::*;
    import hist_stream_pkg::*;
#(
    parameter int PIXELS = hist_cfg_pkg::PIXELS,
    parameter int TS_W   = hist_cfg_pkg::TS_W,
    parameter int BIN_W  = hist_cfg_pkg::BIN_W
) (
    input  logic                         clk,
    input  logic                         combin_res,
    input  logic                         tag_valid,
    input  tagged_event_t                tag,
    input  logic [PIXELS-1:0][BIN_W-1:0] coarse_peaks,
    output logic                         map_valid,
    output bin_update_t                  map
);

    logic [BIN_W-1:0] ts_hi;
    logic [BIN_W-1:0] ts_lo;
    logic             is_coarse;
    logic             keep;

    // coarse bin from the top bits
    assign ts_hi = tag.ts[TS_W-1 -: BIN_W];
    // fine bin from the bottom bits
    assign ts_lo = tag.ts[BIN_W-1:0];

    assign is_coarse = (tag.phase == PHASE_COARSE);

    // fine pass only counts hits inside the coarse peak of this pixel
    assign keep = is_coarse || (ts_hi == coarse_peaks[tag.pix]);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            map_valid <= 1'b0;
        end else begin
            // dropped events still flow, last must reach the memory
            map_valid <= tag_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_valid) begin
            map.pix   <= tag.pix;
            map.bin   <= is_coarse ? ts_hi : ts_lo;
            // filled in by the memory
            map.count <= '0;
            map.phase <= tag.phase;
            map.keep  <= keep;
            map.last  <= tag.last;
        end
    end

endmodule

`default_nettype wire

//--- verilog/hist_event_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module hist_event_sequencer
    import hist_cfg_pkg::*;
    import hist_stream_pkg::*;
#(
    parameter int PIXELS           = hist_cfg_pkg::PIXELS,
    parameter int EVENTS_PER_PIXEL = hist_cfg_pkg::EVENTS_PER_PIXEL,
    parameter int ACQS             = hist_cfg_pkg::ACQS
) (
    input  logic          clk,
    input  logic          combin_res,
    input  logic          ts_valid,
    input  ts_event_t     ts_in,
    output logic          tag_valid,
    output tagged_event_t tag
);

    localparam int EV_W  = (EVENTS_PER_PIXEL > 1) ? $clog2(EVENTS_PER_PIXEL) : 1;
    localparam int ACQ_W = (ACQS > 1) ? $clog2(ACQS) : 1;

    logic [EV_W-1:0]  ev_cnt;
    logic [PIX_W-1:0] pix_cnt;
    logic [ACQ_W-1:0] acq_cnt;
    phase_e           phase;
    logic             ev_wrap;
    logic             pix_wrap;
    logic             acq_wrap;

    // end of each nesting level
    assign ev_wrap  = (ev_cnt == EV_W'(EVENTS_PER_PIXEL - 1));
    assign pix_wrap = (pix_cnt == PIX_W'(PIXELS - 1));
    assign acq_wrap = (acq_cnt == ACQ_W'(ACQS - 1));

    // events inside pixel inside acquisition
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            ev_cnt    <= '0;
            pix_cnt   <= '0;
            acq_cnt   <= '0;
            phase     <= PHASE_COARSE;
            tag_valid <= 1'b0;
        end else begin
            tag_valid <= ts_valid;
            if (ts_valid) begin
                if (!ev_wrap) begin
                    ev_cnt <= ev_cnt + 1'b1;
                end else begin
                    ev_cnt <= '0;
                    if (!pix_wrap) begin
                        pix_cnt <= pix_cnt + 1'b1;
                    end else begin
                        pix_cnt <= '0;
                        if (!acq_wrap) begin
                            acq_cnt <= acq_cnt + 1'b1;
                        end else begin
                            // whole sweep done, swap pass
                            acq_cnt <= '0;
                            phase   <= (phase == PHASE_COARSE) ? PHASE_FINE : PHASE_COARSE;
                        end
                    end
                end
            end
        end
    end

    // tag follows the strobe
    always_ff @(posedge clk) begin
        if (ts_valid) begin
            tag.ts    <= ts_in.ts;
            tag.pix   <= pix_cnt;
            tag.phase <= phase;
            tag.last  <= ev_wrap && pix_wrap && acq_wrap;
        end
    end

    // frame counters stay inside the configured shape
    assert property (@(posedge clk) disable iff (!combin_res)
        int'(ev_cnt) < EVENTS_PER_PIXEL && int'(pix_cnt) < PIXELS && int'(acq_cnt) < ACQS);

endmodule

`default_nettype wire

//--- verilog/hist_stream_pkg.sv
`default_nettype none

package hist_stream_pkg;

    import hist_cfg_pkg::*;

    // raw timestamp from the sensor side
    typedef struct packed {
        logic [TS_W-1:0] ts;
    } ts_event_t;

    // timestamp with its place in the frame
    typedef struct packed {
        logic [TS_W-1:0]  ts;
        logic [PIX_W-1:0] pix;
        phase_e           phase;
        // final event of the phase
        logic             last;
    } tagged_event_t;

    // one histogram bin hit
    typedef struct packed {
        logic [PIX_W-1:0]   pix;
        logic [BIN_W-1:0]   bin;
        logic [COUNT_W-1:0] count;
        phase_e             phase;
        // low for a fine event outside the coarse peak
        logic               keep;
        logic               last;
    } bin_update_t;

    // per-pixel result after the fine pass
    typedef struct packed {
        logic [PIX_W-1:0]   pix;
        logic [BIN_W-1:0]   coarse_bin;
        logic [BIN_W-1:0]   fine_bin;
        logic [COUNT_W-1:0] count;
    } peak_report_t;

endpackage

`default_nettype wire

//--- verilog/hist_cfg_pkg.sv
`default_nettype none

package hist_cfg_pkg;

    // timestamp width
    localparam int TS_W = 8;

    // bin address width
    // upper bits pick the coarse bin, lower bits the fine bin
    localparam int BIN_W = 4;

    // saturating bin counter, tops out at 31
    localparam int COUNT_W = 5;

    // frame shape, events per pixel per acquisition
    localparam int PIXELS = 4;
    localparam int EVENTS_PER_PIXEL = 8;
    localparam int ACQS = 4;

    // pixel index width, at least one bit
    localparam int PIX_W = (PIXELS > 1) ? $clog2(PIXELS) : 1;

    // coarse pass first, then fine pass
    typedef enum logic {PHASE_COARSE = 1'b0, PHASE_FINE = 1'b1} phase_e;

endpackage

`default_nettype wire
